/* Bender.yml */
package:
  name: alu_err_monitor

export_include_dirs:
  - src

sources:
  # Design, in compile order
  - include_dirs:
      - src
    files:
      - src/alu_err_pkg.sv
      - src/op_class_decoder.sv
      - src/leaky_err_counter.sv
      - src/csr_counter_port.sv
      - src/alu_err_monitor.sv

  # Testbench, top module alu_err_monitor_tb
  - target: test
    include_dirs:
      - src
    files:
      - verification/alu_err_monitor_tb.sv

/* flist.f */
+incdir+src
src/alu_err_pkg.sv
src/op_class_decoder.sv
src/leaky_err_counter.sv
src/csr_counter_port.sv
src/alu_err_monitor.sv
verification/alu_err_monitor_tb.sv

/* src/alu_err_monitor.sv */
//////////////////////////////
// ALU error monitor top
// Per-ALU class decode and leaky counters behind a CSR window
//////////////////////////////

`timescale 1ns/1ps

`include "alu_err_settings.svh"

module alu_err_monitor (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [`ALU_COUNT-1:0]                     alu_enable_i,
  input  logic [`ALU_COUNT-1:0][`ALU_OP_WIDTH-1:0]  alu_op_i,
  input  logic [`ALU_COUNT-1:0]                     error_i,
  input  logic                                      div_ready_i,
  input  logic [11:0]                               csr_addr_i,
  input  logic                                      csr_re_i,
  input  logic                                      csr_we_i,
  input  logic [`COUNT_WIDTH-1:0]                   csr_wdata_i,
  output logic [`ALU_COUNT-1:0][`CLASS_COUNT-1:0]   faulty_o,
  output logic [`ALU_COUNT-1:0]                     fault_pulse_o,
  output logic [`COUNT_WIDTH-1:0]                   csr_rdata_o
);

  alu_err_pkg::op_class_e                                    op_class [`ALU_COUNT];
  logic [`ALU_COUNT-1:0]                                     class_valid;
  logic [`ALU_COUNT-1:0][`CLASS_COUNT-1:0][`COUNT_WIDTH-1:0] count;
  logic [`ALU_COUNT-1:0]                                     wr_en;
  alu_err_pkg::op_class_e                                    wr_class;
  logic [`COUNT_WIDTH-1:0]                                   wr_data;

  // One decoder and one counter bank per ALU
  for (genvar a = 0; a < `ALU_COUNT; a++) begin : gen_alu
    op_class_decoder op_class_decoder_inst (
      .alu_enable_i  (alu_enable_i[a]),
      .alu_op_i      (alu_op_i[a]),
      .class_o       (op_class[a]),
      .class_valid_o (class_valid[a])
    );

    leaky_err_counter leaky_err_counter_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .class_i       (op_class[a]),
      .class_valid_i (class_valid[a]),
      .error_i       (error_i[a]),
      .div_ready_i   (div_ready_i),
      .wr_en_i       (wr_en[a]),
      .wr_class_i    (wr_class),
      .wr_data_i     (wr_data),
      .count_o       (count[a]),
      .faulty_o      (faulty_o[a]),
      .fault_pulse_o (fault_pulse_o[a])
    );
  end

  csr_counter_port csr_counter_port_inst (
    .csr_addr_i  (csr_addr_i),
    .csr_re_i    (csr_re_i),
    .csr_we_i    (csr_we_i),
    .csr_wdata_i (csr_wdata_i),
    .count_i     (count),
    .csr_rdata_o (csr_rdata_o),
    .wr_en_o     (wr_en),
    .wr_class_o  (wr_class),
    .wr_data_o   (wr_data)
  );

endmodule

/* src/alu_err_pkg.sv */
//////////////////////////////
// ALU error monitor types
// Operator codes, classes and CSR address layout
//////////////////////////////

`include "alu_err_settings.svh"

package alu_err_pkg;

  // Operator codes of the core ALU that the monitor classifies
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD   = 7'b0011000, ALU_SUB   = 7'b0011001, ALU_ADDU  = 7'b0011010,
    ALU_SUBU  = 7'b0011011, ALU_ADDR  = 7'b0011100, ALU_SUBR  = 7'b0011101,
    ALU_ADDUR = 7'b0011110, ALU_SUBUR = 7'b0011111,
    ALU_SRA   = 7'b0100100, ALU_SRL   = 7'b0100101, ALU_ROR   = 7'b0100110,
    ALU_SLL   = 7'b0100111,
    ALU_XOR   = 7'b0101111, ALU_OR    = 7'b0101110, ALU_AND   = 7'b0010101,
    ALU_BEXT  = 7'b0101000, ALU_BEXTU = 7'b0101001, ALU_BINS  = 7'b0101010,
    ALU_BCLR  = 7'b0101011, ALU_BSET  = 7'b0101100, ALU_BREV  = 7'b1001001,
    ALU_FF1   = 7'b0110110, ALU_FL1   = 7'b0110111, ALU_CNT   = 7'b0110100,
    ALU_CLB   = 7'b0110101,
    ALU_EXTS  = 7'b0111110, ALU_EXT   = 7'b0111111, ALU_SHUF  = 7'b0111010,
    ALU_SHUF2 = 7'b0111011, ALU_PCKLO = 7'b0111000, ALU_PCKHI = 7'b0111001,
    ALU_INS   = 7'b0101101,
    ALU_LTS   = 7'b0000000, ALU_LTU   = 7'b0000001, ALU_LES   = 7'b0000100,
    ALU_LEU   = 7'b0000101, ALU_GTS   = 7'b0001000, ALU_GTU   = 7'b0001001,
    ALU_GES   = 7'b0001010, ALU_GEU   = 7'b0001011, ALU_EQ    = 7'b0001100,
    ALU_NE    = 7'b0001101, ALU_SLTS  = 7'b0000010, ALU_SLTU  = 7'b0000011,
    ALU_SLETS = 7'b0000110, ALU_SLETU = 7'b0000111,
    ALU_ABS   = 7'b0010100, ALU_CLIP  = 7'b0010110, ALU_CLIPU = 7'b0010111,
    ALU_MIN   = 7'b0010000, ALU_MINU  = 7'b0010010, ALU_MAX   = 7'b0010001,
    ALU_MAXU  = 7'b0010011,
    ALU_DIVU  = 7'b0110000, ALU_DIV   = 7'b0110001, ALU_REMU  = 7'b0110010,
    ALU_REM   = 7'b0110011
  } alu_op_e;

  // One leaky counter per class and ALU
  typedef enum logic [3:0] {
    CLS_SHIFT_ADD = 4'd0,
    CLS_LOGIC     = 4'd1,
    CLS_BIT_MAN   = 4'd2,
    CLS_BIT_COUNT = 4'd3,
    CLS_SHUFFLE   = 4'd4,
    CLS_COMPARE   = 4'd5,
    CLS_ABS_CLIP  = 4'd6,
    CLS_MIN_MAX   = 4'd7,
    CLS_DIV_REM   = 4'd8
  } op_class_e;

  // CSR address, either raw or split into page, class and ALU
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic [5:0] page;
      logic [3:0] class_idx;
      logic [1:0] alu_idx;
    } fields;
  } csr_addr_u;

endpackage

/* src/alu_err_settings.svh */
//////////////////////////////
// ALU error monitor settings
// Sizes, fault threshold, leak steps and CSR window
//////////////////////////////

`ifndef ALU_ERR_SETTINGS_SVH
`define ALU_ERR_SETTINGS_SVH

// Monitored ALUs and operation classes per ALU
`define ALU_COUNT 4
`define CLASS_COUNT 9

// Counter and operator widths
`define COUNT_WIDTH 32
`define ALU_OP_WIDTH 7

////////////////////////////////
// Leaky counter behaviour
////////////////////////////////

// Count at which a class is declared permanently faulty
`define ERR_THRESHOLD 16
`define ERR_INC 2
`define ERR_DEC 1

// Upper six address bits of the CSR window at 12'hB40
`define CSR_PAGE 6'h2D

`endif

/* src/csr_counter_port.sv */
//////////////////////////////
// CSR counter port
// Window decode, read mux and write steering
//////////////////////////////

`timescale 1ns/1ps

`include "alu_err_settings.svh"

module csr_counter_port (
  input  alu_err_pkg::csr_addr_u                                    csr_addr_i,
  input  logic                                                      csr_re_i,
  input  logic                                                      csr_we_i,
  input  logic [`COUNT_WIDTH-1:0]                                   csr_wdata_i,
  input  logic [`ALU_COUNT-1:0][`CLASS_COUNT-1:0][`COUNT_WIDTH-1:0] count_i,
  output logic [`COUNT_WIDTH-1:0]                                   csr_rdata_o,
  output logic [`ALU_COUNT-1:0]                                     wr_en_o,
  output alu_err_pkg::op_class_e                                    wr_class_o,
  output logic [`COUNT_WIDTH-1:0]                                   wr_data_o
);

  logic in_window;

  // Page match and a class index that exists
  assign in_window = (csr_addr_i.fields.page == `CSR_PAGE)
                     && (csr_addr_i.fields.class_idx < 4'(`CLASS_COUNT));

  ////////////////////////////////
  // Read path
  ////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    if (csr_re_i && in_window) begin
      csr_rdata_o = count_i[csr_addr_i.fields.alu_idx][csr_addr_i.fields.class_idx];
    end
  end

  ////////////////////////////////
  // Write path
  ////////////////////////////////

  // One-hot ALU select as each bank matches the class itself
  always_comb begin
    wr_en_o = '0;
    if (csr_we_i && in_window) begin
      wr_en_o = `ALU_COUNT'(1) << csr_addr_i.fields.alu_idx;
    end
  end

  assign wr_class_o = alu_err_pkg::op_class_e'(csr_addr_i.fields.class_idx);
  assign wr_data_o  = csr_wdata_i;

endmodule

/* src/leaky_err_counter.sv */
//////////////////////////////
// Leaky error counter bank
// Nine class counters, sticky fault flags and fault pulse of one ALU
//////////////////////////////

`timescale 1ns/1ps

`include "alu_err_settings.svh"

module leaky_err_counter (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  alu_err_pkg::op_class_e                       class_i,
  input  logic                                         class_valid_i,
  input  logic                                         error_i,
  input  logic                                         div_ready_i,
  input  logic                                         wr_en_i,
  input  alu_err_pkg::op_class_e                       wr_class_i,
  input  logic [`COUNT_WIDTH-1:0]                      wr_data_i,
  output logic [`CLASS_COUNT-1:0][`COUNT_WIDTH-1:0]    count_o,
  output logic [`CLASS_COUNT-1:0]                      faulty_o,
  output logic                                         fault_pulse_o
);

  localparam logic [`COUNT_WIDTH-1:0] STEP_INC  = `COUNT_WIDTH'(`ERR_INC);
  localparam logic [`COUNT_WIDTH-1:0] STEP_DEC  = `COUNT_WIDTH'(`ERR_DEC);
  localparam logic [`COUNT_WIDTH-1:0] THRESHOLD = `COUNT_WIDTH'(`ERR_THRESHOLD);

  logic [`CLASS_COUNT-1:0][`COUNT_WIDTH-1:0] count_q;
  logic [`CLASS_COUNT-1:0][`COUNT_WIDTH-1:0] count_d;
  logic [`CLASS_COUNT-1:0]                   faulty_q;
  logic [`CLASS_COUNT-1:0]                   faulty_d;
  logic [`CLASS_COUNT-1:0]                   step_en;
  logic                                      fault_pulse_q;

  ////////////////////////////////
  // Per-class update enable
  ////////////////////////////////

  // A faulty class stays frozen
  for (genvar c = 0; c < `CLASS_COUNT; c++) begin : gen_step_en
    if (c == alu_err_pkg::CLS_DIV_REM) begin : gen_div
      // Divider result is only checked once it is done
      assign step_en[c] = class_valid_i && (class_i == alu_err_pkg::op_class_e'(c))
                          && !faulty_q[c] && div_ready_i;
    end else begin : gen_plain
      assign step_en[c] = class_valid_i && (class_i == alu_err_pkg::op_class_e'(c))
                          && !faulty_q[c];
    end
  end

  ////////////////////////////////
  // Next count and flags
  ////////////////////////////////

  always_comb begin
    count_d  = count_q;
    faulty_d = faulty_q;
    for (int c = 0; c < `CLASS_COUNT; c++) begin
      if (wr_en_i && (wr_class_i == alu_err_pkg::op_class_e'(c))) begin
        // CSR write beats the error update
        count_d[c] = wr_data_i;
      end else if (step_en[c]) begin
        if (error_i) begin
          count_d[c] = count_q[c] + STEP_INC;
          if (count_d[c] >= THRESHOLD) begin
            faulty_d[c] = 1'b1;
          end
        end else if (count_q[c] > STEP_DEC) begin
          count_d[c] = count_q[c] - STEP_DEC;
        end else begin
          count_d[c] = '0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q       <= '0;
      faulty_q      <= '0;
      fault_pulse_q <= 1'b0;
    end else begin
      count_q       <= count_d;
      faulty_q      <= faulty_d;
      // High in the cycle a new flag first shows
      fault_pulse_q <= |(faulty_d & ~faulty_q);
    end
  end

  assign count_o       = count_q;
  assign faulty_o      = faulty_q;
  assign fault_pulse_o = fault_pulse_q;

endmodule

/* src/op_class_decoder.sv */
//////////////////////////////
// Operator class decoder
// Maps an ALU operator to its monitored class
//////////////////////////////

`timescale 1ns/1ps

`include "alu_err_settings.svh"

module op_class_decoder (
  input  logic                      alu_enable_i,
  input  logic [`ALU_OP_WIDTH-1:0]  alu_op_i,
  output alu_err_pkg::op_class_e    class_o,
  output logic                      class_valid_o
);

  logic known_op;

  always_comb begin
    class_o  = alu_err_pkg::CLS_SHIFT_ADD;
    known_op = 1'b1;
    case (alu_op_i)
      alu_err_pkg::ALU_ADD, alu_err_pkg::ALU_SUB, alu_err_pkg::ALU_ADDU,
      alu_err_pkg::ALU_SUBU, alu_err_pkg::ALU_ADDR, alu_err_pkg::ALU_SUBR,
      alu_err_pkg::ALU_ADDUR, alu_err_pkg::ALU_SUBUR, alu_err_pkg::ALU_SRA,
      alu_err_pkg::ALU_SRL, alu_err_pkg::ALU_ROR, alu_err_pkg::ALU_SLL:
        class_o = alu_err_pkg::CLS_SHIFT_ADD;
      alu_err_pkg::ALU_XOR, alu_err_pkg::ALU_OR, alu_err_pkg::ALU_AND:
        class_o = alu_err_pkg::CLS_LOGIC;
      alu_err_pkg::ALU_BEXT, alu_err_pkg::ALU_BEXTU, alu_err_pkg::ALU_BINS,
      alu_err_pkg::ALU_BCLR, alu_err_pkg::ALU_BSET, alu_err_pkg::ALU_BREV:
        class_o = alu_err_pkg::CLS_BIT_MAN;
      alu_err_pkg::ALU_FF1, alu_err_pkg::ALU_FL1, alu_err_pkg::ALU_CNT,
      alu_err_pkg::ALU_CLB:
        class_o = alu_err_pkg::CLS_BIT_COUNT;
      alu_err_pkg::ALU_EXTS, alu_err_pkg::ALU_EXT, alu_err_pkg::ALU_SHUF,
      alu_err_pkg::ALU_SHUF2, alu_err_pkg::ALU_PCKLO, alu_err_pkg::ALU_PCKHI,
      alu_err_pkg::ALU_INS:
        class_o = alu_err_pkg::CLS_SHUFFLE;
      // Comparisons include the set-less-than forms
      alu_err_pkg::ALU_LTS, alu_err_pkg::ALU_LTU, alu_err_pkg::ALU_LES,
      alu_err_pkg::ALU_LEU, alu_err_pkg::ALU_GTS, alu_err_pkg::ALU_GTU,
      alu_err_pkg::ALU_GES, alu_err_pkg::ALU_GEU, alu_err_pkg::ALU_EQ,
      alu_err_pkg::ALU_NE, alu_err_pkg::ALU_SLTS, alu_err_pkg::ALU_SLTU,
      alu_err_pkg::ALU_SLETS, alu_err_pkg::ALU_SLETU:
        class_o = alu_err_pkg::CLS_COMPARE;
      alu_err_pkg::ALU_ABS, alu_err_pkg::ALU_CLIP, alu_err_pkg::ALU_CLIPU:
        class_o = alu_err_pkg::CLS_ABS_CLIP;
      alu_err_pkg::ALU_MIN, alu_err_pkg::ALU_MINU, alu_err_pkg::ALU_MAX,
      alu_err_pkg::ALU_MAXU:
        class_o = alu_err_pkg::CLS_MIN_MAX;
      alu_err_pkg::ALU_DIVU, alu_err_pkg::ALU_DIV, alu_err_pkg::ALU_REMU,
      alu_err_pkg::ALU_REM:
        class_o = alu_err_pkg::CLS_DIV_REM;
      default:
        known_op = 1'b0;
    endcase
  end

  // Idle ALU or foreign opcode touches no counter
  assign class_valid_o = alu_enable_i & known_op;

endmodule

/* verification/alu_err_monitor_tb.sv */
//////////////////////////////
// ALU error monitor testbench
// Random and directed stimulus checked against a reference model
//////////////////////////////

`timescale 1ns/1ps

`include "alu_err_settings.svh"

module alu_err_monitor_tb;

  localparam int CLK_PERIOD = 20;
  // Cycle budget of each test summed up for the watchdog
  localparam int RESET_CYCLES = 60;
  localparam int LEAKY_CYCLES = 460;
  localparam int FAULT_CYCLES = 30;
  localparam int DIV_CYCLES   = 30;
  localparam int CSR_CYCLES   = 70;
  localparam int TOTAL_CYCLES = RESET_CYCLES + LEAKY_CYCLES + FAULT_CYCLES + DIV_CYCLES
                                + CSR_CYCLES;
  localparam int FAULT_ALU    = 2;

  logic                                     clk;
  logic                                     rst_n;
  logic [`ALU_COUNT-1:0]                    alu_en;
  logic [`ALU_COUNT-1:0][`ALU_OP_WIDTH-1:0] alu_op;
  logic [`ALU_COUNT-1:0]                    err;
  logic                                     div_ready;
  logic [11:0]                              csr_addr;
  logic                                     csr_re;
  logic                                     csr_we;
  logic [`COUNT_WIDTH-1:0]                  csr_wdata;
  logic [`ALU_COUNT-1:0][`CLASS_COUNT-1:0]  faulty;
  logic [`ALU_COUNT-1:0]                    pulse;
  logic [`COUNT_WIDTH-1:0]                  rdata;

  // Reference model state
  logic [`COUNT_WIDTH-1:0] ref_count [`ALU_COUNT][`CLASS_COUNT];
  logic [`CLASS_COUNT-1:0] ref_faulty [`ALU_COUNT];
  logic [`ALU_COUNT-1:0]   ref_pulse;

  logic [31:0] rng = 32'h2670_cf64;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          pulse_seen [`ALU_COUNT];

  alu_err_monitor alu_err_monitor_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_enable_i  (alu_en),
    .alu_op_i      (alu_op),
    .error_i       (err),
    .div_ready_i   (div_ready),
    .csr_addr_i    (csr_addr),
    .csr_re_i      (csr_re),
    .csr_we_i      (csr_we),
    .csr_wdata_i   (csr_wdata),
    .faulty_o      (faulty),
    .fault_pulse_o (pulse),
    .csr_rdata_o   (rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  ////////////////////////////////
  // Reference model
  ////////////////////////////////

  // Valid bit on top, class below
  function automatic logic [4:0] class_of(input logic [`ALU_OP_WIDTH-1:0] op);
    case (op)
      alu_err_pkg::ALU_ADD, alu_err_pkg::ALU_SUB, alu_err_pkg::ALU_ADDU, alu_err_pkg::ALU_SUBU,
      alu_err_pkg::ALU_ADDR, alu_err_pkg::ALU_SUBR, alu_err_pkg::ALU_ADDUR,
      alu_err_pkg::ALU_SUBUR, alu_err_pkg::ALU_SRA, alu_err_pkg::ALU_SRL,
      alu_err_pkg::ALU_ROR, alu_err_pkg::ALU_SLL:
        return {1'b1, alu_err_pkg::CLS_SHIFT_ADD};
      alu_err_pkg::ALU_XOR, alu_err_pkg::ALU_OR, alu_err_pkg::ALU_AND:
        return {1'b1, alu_err_pkg::CLS_LOGIC};
      alu_err_pkg::ALU_BEXT, alu_err_pkg::ALU_BEXTU, alu_err_pkg::ALU_BINS,
      alu_err_pkg::ALU_BCLR, alu_err_pkg::ALU_BSET, alu_err_pkg::ALU_BREV:
        return {1'b1, alu_err_pkg::CLS_BIT_MAN};
      alu_err_pkg::ALU_FF1, alu_err_pkg::ALU_FL1, alu_err_pkg::ALU_CNT, alu_err_pkg::ALU_CLB:
        return {1'b1, alu_err_pkg::CLS_BIT_COUNT};
      alu_err_pkg::ALU_EXTS, alu_err_pkg::ALU_EXT, alu_err_pkg::ALU_SHUF,
      alu_err_pkg::ALU_SHUF2, alu_err_pkg::ALU_PCKLO, alu_err_pkg::ALU_PCKHI,
      alu_err_pkg::ALU_INS:
        return {1'b1, alu_err_pkg::CLS_SHUFFLE};
      alu_err_pkg::ALU_LTS, alu_err_pkg::ALU_LTU, alu_err_pkg::ALU_LES, alu_err_pkg::ALU_LEU,
      alu_err_pkg::ALU_GTS, alu_err_pkg::ALU_GTU, alu_err_pkg::ALU_GES, alu_err_pkg::ALU_GEU,
      alu_err_pkg::ALU_EQ, alu_err_pkg::ALU_NE, alu_err_pkg::ALU_SLTS, alu_err_pkg::ALU_SLTU,
      alu_err_pkg::ALU_SLETS, alu_err_pkg::ALU_SLETU:
        return {1'b1, alu_err_pkg::CLS_COMPARE};
      alu_err_pkg::ALU_ABS, alu_err_pkg::ALU_CLIP, alu_err_pkg::ALU_CLIPU:
        return {1'b1, alu_err_pkg::CLS_ABS_CLIP};
      alu_err_pkg::ALU_MIN, alu_err_pkg::ALU_MINU, alu_err_pkg::ALU_MAX, alu_err_pkg::ALU_MAXU:
        return {1'b1, alu_err_pkg::CLS_MIN_MAX};
      alu_err_pkg::ALU_DIVU, alu_err_pkg::ALU_DIV, alu_err_pkg::ALU_REMU, alu_err_pkg::ALU_REM:
        return {1'b1, alu_err_pkg::CLS_DIV_REM};
      default:
        return 5'b0;
    endcase
  endfunction

  function automatic logic in_window(input alu_err_pkg::csr_addr_u ad);
    return (ad.fields.page == `CSR_PAGE) && (ad.fields.class_idx < `CLASS_COUNT);
  endfunction

  function automatic void ref_reset();
    for (int a = 0; a < `ALU_COUNT; a++) begin
      for (int c = 0; c < `CLASS_COUNT; c++) begin
        ref_count[a][c] = '0;
      end
      ref_faulty[a] = '0;
    end
    ref_pulse = '0;
  endfunction

  function automatic void ref_update();
    alu_err_pkg::csr_addr_u wa;
    logic [4:0]             cls;
    logic                   hit;
    wa.raw = csr_addr;
    for (int a = 0; a < `ALU_COUNT; a++) begin
      cls = class_of(alu_op[a]);
      ref_pulse[a] = 1'b0;
      for (int c = 0; c < `CLASS_COUNT; c++) begin
        hit = alu_en[a] && cls[4] && (cls[3:0] == c) && !ref_faulty[a][c]
              && ((c != alu_err_pkg::CLS_DIV_REM) || div_ready);
        if (csr_we && in_window(wa) && (wa.fields.alu_idx == a)
            && (wa.fields.class_idx == c)) begin
          ref_count[a][c] = csr_wdata;
        end else if (hit && err[a]) begin
          ref_count[a][c] = ref_count[a][c] + `ERR_INC;
          if (ref_count[a][c] >= `ERR_THRESHOLD) begin
            ref_faulty[a][c] = 1'b1;
            ref_pulse[a] = 1'b1;
          end
        end else if (hit) begin
          ref_count[a][c] = (ref_count[a][c] > `ERR_DEC) ? ref_count[a][c] - `ERR_DEC : '0;
        end
      end
    end
  endfunction

  function automatic logic [`COUNT_WIDTH-1:0] expected_rdata();
    alu_err_pkg::csr_addr_u ra;
    ra.raw = csr_addr;
    if (csr_re && in_window(ra)) begin
      return ref_count[ra.fields.alu_idx][ra.fields.class_idx];
    end
    return '0;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_reset();
    end else begin
      ref_update();
    end
  end

  ////////////////////////////////
  // Compare process
  ////////////////////////////////

  // Outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    for (int a = 0; a < `ALU_COUNT; a++) begin
      assert (faulty[a] === ref_faulty[a]) else begin
        $display("mismatch at %0t: faulty_o of ALU %0d is %b, expected %b",
                 $time, a, faulty[a], ref_faulty[a]);
        errors++;
      end
      if (pulse[a] === 1'b1) begin
        pulse_seen[a]++;
      end
    end
    assert (pulse === ref_pulse) else begin
      $display("mismatch at %0t: fault_pulse_o is %b, expected %b", $time, pulse, ref_pulse);
      errors++;
    end
    assert (rdata === expected_rdata()) else begin
      $display("mismatch at %0t: csr_rdata_o is %0d at address %h, expected %0d",
               $time, rdata, csr_addr, expected_rdata());
      errors++;
    end
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + 1000);
    $display("Watchdog expired after %0d cycles, the tests did not complete", TOTAL_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////

  task automatic check_read(input logic [`COUNT_WIDTH-1:0] expected, input string what);
    assert (rdata === expected) else begin
      $display("mismatch at %0t: %s, csr_rdata_o is %0d, expected %0d",
               $time, what, rdata, expected);
      errors++;
    end
  endtask

  // One ALU active, the others idle, for n cycles
  task automatic drive_alu(input int a, input logic [`ALU_OP_WIDTH-1:0] op, input logic e,
                           input logic ready, input int n);
    repeat (n) begin
      @(posedge clk);
      alu_en    <= `ALU_COUNT'(1) << a;
      alu_op    <= {`ALU_COUNT{op}};
      err       <= e ? (`ALU_COUNT'(1) << a) : '0;
      div_ready <= ready;
    end
  endtask

  // Last drive gets sampled, then outputs are looked at
  task automatic quiesce();
    @(posedge clk);
    alu_en <= '0;
    err    <= '0;
    @(negedge clk);
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [`COUNT_WIDTH-1:0] data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_re    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we <= 1'b0;
  endtask

  task automatic sweep_reads();
    for (int a = 0; a < `ALU_COUNT; a++) begin
      for (int c = 0; c < `CLASS_COUNT; c++) begin
        @(posedge clk);
        csr_re   <= 1'b1;
        csr_addr <= {`CSR_PAGE, 4'(c), 2'(a)};
      end
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests_run++;
    if (errors != start_errors) begin
      tests_failed++;
    end
    $display("Test %-16s finished with %0d errors", name, errors - start_errors);
  endtask

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////

  initial begin
    int          start;
    logic [31:0] r;
    logic [31:0] wval;
    logic [31:0] frozen;
    clk       = 1'b0;
    rst_n     = 1'b0;
    alu_en    = '0;
    alu_op    = '0;
    err       = '0;
    div_ready = 1'b0;
    csr_addr  = '0;
    csr_re    = 1'b0;
    csr_we    = 1'b0;
    csr_wdata = '0;

    // Reset state
    start = errors;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert ((faulty === '0) && (pulse === '0)) else begin
      $display("mismatch at %0t: faulty_o or fault_pulse_o not clear after reset", $time);
      errors++;
    end
    sweep_reads();
    @(posedge clk);
    csr_re   <= 1'b0;
    csr_addr <= {`CSR_PAGE, 4'd0, 2'd0};
    @(negedge clk);
    check_read('0, "read with csr_re_i low");
    end_test("reset", start);

    // Leaky counting with sparse errors
    start = errors;
    repeat (400) begin
      @(posedge clk);
      r = xorshift32();
      alu_op <= r[27:0];
      r = xorshift32();
      alu_en    <= r[3:0];
      err       <= r[7:4] & r[11:8] & r[15:12];
      div_ready <= r[16];
      csr_re    <= 1'b1;
      csr_addr  <= {`CSR_PAGE, r[23:20] % 4'd9, r[25:24]};
    end
    quiesce();
    sweep_reads();
    end_test("leaky_counting", start);

    // Permanent fault on one ALU and class
    start = errors;
    for (int a = 0; a < `ALU_COUNT; a++) begin
      pulse_seen[a] = 0;
    end
    csr_write({`CSR_PAGE, alu_err_pkg::CLS_LOGIC, 2'(FAULT_ALU)}, '0);
    for (int i = 1; i <= 12; i++) begin
      drive_alu(FAULT_ALU, alu_err_pkg::ALU_AND, 1'b1, 1'b0, 1);
      @(negedge clk);
      assert (faulty[FAULT_ALU][alu_err_pkg::CLS_LOGIC]
              === (`ERR_INC * (i - 1) >= `ERR_THRESHOLD)) else begin
        $display("mismatch at %0t: fault flag wrong after %0d errors", $time, i - 1);
        errors++;
      end
    end
    quiesce();
    frozen = 0;
    while (frozen < `ERR_THRESHOLD) begin
      frozen = frozen + `ERR_INC;
    end
    check_read(frozen, "faulty counter kept counting");
    assert ((pulse_seen[FAULT_ALU] == 1) && (pulse_seen[0] + pulse_seen[1] + pulse_seen[3] == 0))
    else begin
      $display("Fault pulse of ALU %0d was seen %0d times instead of once, or another ALU pulsed",
               FAULT_ALU, pulse_seen[FAULT_ALU]);
      errors++;
    end
    end_test("permanent_fault", start);

    // Divide class waits for the divider
    start = errors;
    csr_write({`CSR_PAGE, alu_err_pkg::CLS_DIV_REM, 2'd0}, 32'd5);
    drive_alu(0, alu_err_pkg::ALU_DIV, 1'b1, 1'b0, 6);
    quiesce();
    check_read(32'd5, "divide counter moved while divider busy");
    drive_alu(0, alu_err_pkg::ALU_DIV, 1'b1, 1'b1, 3);
    quiesce();
    check_read(32'd5 + 3 * `ERR_INC, "divide errors with divider ready");
    drive_alu(0, alu_err_pkg::ALU_REM, 1'b0, 1'b1, 2);
    quiesce();
    check_read(32'd5 + 3 * `ERR_INC - 2 * `ERR_DEC, "clean divides with divider ready");
    end_test("divide_gating", start);

    // CSR writes, write against error update, writes outside the window
    start = errors;
    wval = xorshift32();
    @(posedge clk);
    alu_en    <= 4'b1000;
    alu_op    <= {`ALU_COUNT{alu_err_pkg::ALU_MIN}};
    err       <= 4'b1000;
    csr_we    <= 1'b1;
    csr_re    <= 1'b1;
    csr_addr  <= {`CSR_PAGE, alu_err_pkg::CLS_MIN_MAX, 2'd3};
    csr_wdata <= wval;
    @(posedge clk);
    csr_we <= 1'b0;
    alu_en <= '0;
    err    <= '0;
    @(negedge clk);
    check_read(wval, "write lost against an error update");
    csr_write({`CSR_PAGE, 4'd9, 2'd1}, 32'hdead_beef);
    @(negedge clk);
    check_read('0, "class index 9 reads nonzero");
    csr_write({`CSR_PAGE, 4'd15, 2'd0}, 32'h1234_5678);
    @(negedge clk);
    check_read('0, "class index 15 reads nonzero");
    csr_write({6'h2C, alu_err_pkg::CLS_BIT_MAN, 2'd1}, 32'h0bad_f00d);
    @(negedge clk);
    check_read('0, "address outside the page reads nonzero");
    sweep_reads();
    @(negedge clk);
    end_test("csr_writes", start);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
